//--- mad_consts.svh
`ifndef MAD_CONSTS_SVH
`define MAD_CONSTS_SVH

// ===========================================================================
// Multiply-add engine build constants
// ===========================================================================

// Bit width of a, b, c and of the truncated result
`define MAD_WIDTH	32

// Clocks a core keeps its operands stable before the result is taken
// Must be 1 or more
`define MAD_CYCLE	3

// Number of parallel cores in flight, 1 or more
`define MAD_COUNT	2

// Round-robin pointer width, wide enough to index MAD_COUNT cores
// Kept at 1 even for a single core so the pointer never has zero width
`define MAD_IDX_W	1

`endif

//--- mad_pkg.sv
`default_nettype none

`include "mad_consts.svh"

package mad_pkg;

	// =======================================================================
	// Operand triple for one multiply-add
	// =======================================================================

	// Result is a*b+c, truncated to MAD_WIDTH bits
	typedef struct packed {
		logic [`MAD_WIDTH-1:0]	a;
		logic [`MAD_WIDTH-1:0]	b;
		logic [`MAD_WIDTH-1:0]	c;
	} mad_operands_t;

	// =======================================================================
	// Per-core result toward the collector
	// =======================================================================

	// done is a single-cycle strobe
	// value only meaningful while done is high
	typedef struct packed {
		logic					done;
		logic [`MAD_WIDTH-1:0]	value;
	} mad_result_t;

endpackage

`default_nettype wire

//--- mad_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "mad_consts.svh"

module mad_core (
	input  logic					MCLK,
	input  logic					nRST,
	input  logic					issue,
	input  mad_pkg::mad_operands_t	operands,
	output logic					free,
	output mad_pkg::mad_result_t	result
);

	// Down-counter must be able to hold MAD_CYCLE itself
	localparam int CNT_W = $clog2(`MAD_CYCLE + 1);

	// =======================================================================
	// Operand hold and cycle counter
	// =======================================================================

	// Operands captured on the issue edge and held for the whole operation
	mad_pkg::mad_operands_t	hold;

	// Operation in progress
	logic					busy;

	// Edges left until the result may be sampled
	logic [CNT_W-1:0]		cnt;

	// Counter has run out while busy
	logic					done;

	// Payload register, loaded only on issue
	always_ff @(posedge MCLK) begin
		if (issue) begin
			hold <= operands;
		end
	end

	// Control state
	always_ff @(posedge MCLK or negedge nRST) begin
		if (!nRST) begin
			busy <= 1'b0;
			cnt  <= '0;
		end else if (issue) begin
			// Issue edge starts a new operation, also right after done
			busy <= 1'b1;
			cnt  <= CNT_W'(`MAD_CYCLE);
		end else if (busy) begin
			if (cnt == '0) begin
				busy <= 1'b0;
			end else begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	// =======================================================================
	// Multicycle datapath
	// =======================================================================

	// Fed from the hold register only
	// The inputs stay stable for MAD_CYCLE clocks before done
	always_comb begin
		result.value = hold.a * hold.b + hold.c;
	end

	// Done lands MAD_CYCLE edges after issue
	assign done = busy && (cnt == '0);

	always_comb begin
		result.done = done;
	end

	// Free again in the done cycle
	// So the dispatcher may reissue on the very next edge
	assign free = ~busy | done;

endmodule

`default_nettype wire

//--- mad_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "mad_consts.svh"

module mad_dispatch (
	input  logic					MCLK,
	input  logic					nRST,
	input  logic					ie,
	output logic					iready,
	input  mad_pkg::mad_operands_t	operands,
	input  logic [`MAD_COUNT-1:0]	core_free,
	output logic [`MAD_COUNT-1:0]	issue,
	output mad_pkg::mad_operands_t	core_operands
);

	// Index of the last core, where the pointer wraps
	localparam logic [`MAD_IDX_W-1:0] LAST_IDX = (`MAD_IDX_W)'(`MAD_COUNT - 1);

	// =======================================================================
	// Issue pointer and handshake
	// =======================================================================

	// Core that receives the next accepted operand triple
	logic [`MAD_IDX_W-1:0]	issue_ptr;

	// Transfer on this edge
	logic					xfer;

	// Ready follows only the pointed core
	// Strict round-robin keeps results in order
	assign iready = core_free[issue_ptr];

	assign xfer = ie & iready;

	// One-hot issue strobe toward the pointed core
	always_comb begin
		issue = '0;
		if (xfer) begin
			issue[issue_ptr] = 1'b1;
		end
	end

	// Shared operand bus
	// Only the core with its issue bit set captures it
	assign core_operands = operands;

	// =======================================================================
	// Pointer advance
	// =======================================================================

	always_ff @(posedge MCLK or negedge nRST) begin
		if (!nRST) begin
			issue_ptr <= '0;
		end else if (xfer) begin
			// Wrap after the last core
			if (issue_ptr == LAST_IDX) begin
				issue_ptr <= '0;
			end else begin
				issue_ptr <= issue_ptr + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- mad_collect.sv
`timescale 1ns/1ps
`default_nettype none

`include "mad_consts.svh"

module mad_collect (
	input  logic					MCLK,
	input  logic					nRST,
	input  mad_pkg::mad_result_t	core_result [`MAD_COUNT],
	output logic					oe,
	output logic [`MAD_WIDTH-1:0]	odata
);

	// Index of the last core, where the pointer wraps
	localparam logic [`MAD_IDX_W-1:0] LAST_IDX = (`MAD_IDX_W)'(`MAD_COUNT - 1);

	// =======================================================================
	// Collect pointer
	// =======================================================================

	// Core whose result is due next, in issue order
	logic [`MAD_IDX_W-1:0]	collect_ptr;

	// Result currently under the pointer
	mad_pkg::mad_result_t	cur;

	// Other cores are ignored
	// Equal latency means they cannot finish first
	assign cur = core_result[collect_ptr];

	always_ff @(posedge MCLK or negedge nRST) begin
		if (!nRST) begin
			collect_ptr <= '0;
		end else if (cur.done) begin
			if (collect_ptr == LAST_IDX) begin
				collect_ptr <= '0;
			end else begin
				collect_ptr <= collect_ptr + 1'b1;
			end
		end
	end

	// =======================================================================
	// Registered output
	// =======================================================================

	// One-cycle valid strobe, no back-pressure on the output side
	always_ff @(posedge MCLK or negedge nRST) begin
		if (!nRST) begin
			oe <= 1'b0;
		end else begin
			oe <= cur.done;
		end
	end

	// Data holds its last value between strobes
	// Zero after reset
	always_ff @(posedge MCLK or negedge nRST) begin
		if (!nRST) begin
			odata <= '0;
		end else if (cur.done) begin
			odata <= cur.value;
		end
	end

endmodule

`default_nettype wire

//--- mad_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mad_consts.svh"

module mad_top (
	input  logic					MCLK,
	input  logic					nRST,
	input  logic					ie,
	output logic					iready,
	input  mad_pkg::mad_operands_t	operands,
	output logic					oe,
	output logic [`MAD_WIDTH-1:0]	odata
);

	// =======================================================================
	// Internal nets
	// =======================================================================

	// Per-core free flags back to the dispatcher
	logic [`MAD_COUNT-1:0]	core_free;

	// One-hot issue strobes
	logic [`MAD_COUNT-1:0]	issue;

	// Shared operand bus
	mad_pkg::mad_operands_t	core_operands;

	// Per-core results toward the collector
	mad_pkg::mad_result_t	core_result [`MAD_COUNT];

	// =======================================================================
	// Dispatcher, core array, collector
	// =======================================================================

	mad_dispatch mad_dispatch_inst (
		.MCLK			(MCLK),
		.nRST			(nRST),
		.ie				(ie),
		.iready			(iready),
		.operands		(operands),
		.core_free		(core_free),
		.issue			(issue),
		.core_operands	(core_operands)
	);

	// Identical cores, each picked in turn by the issue pointer
	for (genvar i = 0; i < `MAD_COUNT; i++) begin : g_core
		mad_core mad_core_inst (
			.MCLK		(MCLK),
			.nRST		(nRST),
			.issue		(issue[i]),
			.operands	(core_operands),
			.free		(core_free[i]),
			.result		(core_result[i])
		);
	end

	mad_collect mad_collect_inst (
		.MCLK			(MCLK),
		.nRST			(nRST),
		.core_result	(core_result),
		.oe				(oe),
		.odata			(odata)
	);

endmodule

`default_nettype wire

//--- tb_mad_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mad_consts.svh"

module tb_mad_top;

	localparam int          W          = `MAD_WIDTH;
	localparam int unsigned LAT        = `MAD_CYCLE + 1;
	localparam int unsigned CYC        = `MAD_CYCLE;
	localparam int unsigned CNT        = `MAD_COUNT;
	localparam int          HALF_NS    = 10;
	localparam int          RST_CYCLES = 4;
	localparam int          NUM_ROWS   = 16;
	localparam int          NUM_RANDOM = 64;
	localparam logic [31:0] SEED       = 32'd62183;

	// Table applied twice, once spaced out and once back-to-back
	localparam int APPLIED   = 2 * NUM_ROWS + NUM_RANDOM;
	localparam int WATCHDOG_NS = APPLIED * (`MAD_CYCLE + 8) * 2 * HALF_NS
		+ (RST_CYCLES + 1) * 2 * HALF_NS;

	// One stimulus row, operands then expected result then idle cycles
	typedef struct packed {
		mad_pkg::mad_operands_t	ops;
		logic [W-1:0]			result;
		logic [7:0]				gap;
	} row_t;

	// Outstanding operation with its acceptance edge
	typedef struct packed {
		logic [W-1:0]	value;
		logic [31:0]	edge_no;
	} pending_t;

	logic					MCLK;
	logic					nRST;
	logic					ie;
	logic					iready;
	mad_pkg::mad_operands_t	operands;
	logic					oe;
	logic [W-1:0]			odata;

	// Rising edges seen since time zero
	int unsigned			edge_cnt = 0;
	pending_t				exp_q [$];
	int unsigned			acc_hist [$];
	logic [31:0]			rng_state;

	// ========================================================================
	// Stimulus table
	// ========================================================================

	// Columns are a, b, c, expected a*b+c mod 2^32, idle cycles after the row
	row_t stim_table [NUM_ROWS] = '{
		{32'd3,  32'd4,  32'd5,  32'd17,  8'd6},
		{32'd5,  32'd6,  32'd7,  32'd37,  8'd5},
		{32'd7,  32'd8,  32'd9,  32'd65,  8'd7},
		{32'd9,  32'd10, 32'd11, 32'd101, 8'd6},
		{32'd11, 32'd12, 32'd13, 32'd145, 8'd5},
		{32'd13, 32'd14, 32'd15, 32'd197, 8'd8},
		{32'd15, 32'd16, 32'd17, 32'd257, 8'd6},
		{32'd17, 32'd18, 32'd19, 32'd325, 8'd5},
		{32'd19, 32'd20, 32'd21, 32'd401, 8'd7},
		// All ones wraps to zero
		{32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000, 8'd6},
		{32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 8'd5},
		{32'h0000_0000, 32'hFFFF_FFFF, 32'h0000_0005, 32'h0000_0005, 8'd6},
		// Product exactly 2^32
		{32'h0001_0000, 32'h0001_0000, 32'h0000_0007, 32'h0000_0007, 8'd5},
		{32'hFFFF_FFFF, 32'h0000_0002, 32'h0000_0003, 32'h0000_0001, 8'd6},
		{32'h1234_5678, 32'h0000_0010, 32'h0000_0001, 32'h2345_6781, 8'd5},
		{32'h8000_0001, 32'h0000_0003, 32'h0000_0000, 32'h8000_0003, 8'd6}
	};

	mad_top mad_top_inst (
		.MCLK		(MCLK),
		.nRST		(nRST),
		.ie			(ie),
		.iready		(iready),
		.operands	(operands),
		.oe			(oe),
		.odata		(odata)
	);

	initial MCLK = 1'b0;
	always #(HALF_NS) MCLK = ~MCLK;

	always @(posedge MCLK) begin
		edge_cnt <= edge_cnt + 1;
	end

	// ========================================================================
	// Reference model and helpers
	// ========================================================================

	// Full-width product and sum, then keep the low W bits
	function automatic logic [W-1:0] ref_mad(input mad_pkg::mad_operands_t ops);
		logic [2*W-1:0] full;
		full = {{W{1'b0}}, ops.a} * {{W{1'b0}}, ops.b};
		full = full + {{W{1'b0}}, ops.c};
		return full[W-1:0];
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("[FAIL] %0d ns: %s", $time, msg);
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped on a wrong value");
	endtask

	task automatic report_problem(input string msg);
		$display("Check failed at %0d ns: %s", $time, msg);
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped on a failed check");
	endtask

	// Idle outputs, used in and right after reset
	task automatic check_idle();
		assert (oe == 1'b0)
		else report_mismatch($sformatf("oe is %b while idle", oe));
		assert (iready == 1'b1)
		else report_mismatch($sformatf("iready is %b while idle", iready));
		assert (odata == '0)
		else report_mismatch($sformatf("odata is %h while idle", odata));
	endtask

	// At most CNT transfers in any CYC consecutive edges
	task automatic check_rate(input int unsigned e);
		while (acc_hist.size() > 0 && (e - acc_hist[0]) >= CYC) begin
			void'(acc_hist.pop_front());
		end
		assert (acc_hist.size() < CNT)
		else report_problem($sformatf("too many transfers accepted before edge %0d", e));
		acc_hist.push_back(e);
	endtask

	// Hold ie until accepted, then idle for gap cycles
	// iready only moves after a rising edge, so it is stable at the falling edge
	task automatic send_op(input mad_pkg::mad_operands_t ops, input logic [W-1:0] exp_val,
			input int gap);
		pending_t ent;
		int k;
		@(negedge MCLK);
		ie = 1'b1;
		operands = ops;
		while (!iready) begin
			@(negedge MCLK);
		end
		ent.value = exp_val;
		ent.edge_no = edge_cnt + 1;
		check_rate(ent.edge_no);
		exp_q.push_back(ent);
		for (k = 0; k < gap; k++) begin
			@(negedge MCLK);
			ie = 1'b0;
		end
	endtask

	// ========================================================================
	// Output monitor
	// ========================================================================

	// Registered outputs settle well before the falling edge
	always @(negedge MCLK) begin
		pending_t head;
		if (nRST) begin
			if (oe) begin
				assert (exp_q.size() > 0)
				else report_problem("result strobe seen with nothing outstanding");
				head = exp_q.pop_front();
				assert (odata == head.value)
				else report_mismatch($sformatf("odata %h, expected %h", odata, head.value));
				assert (edge_cnt == head.edge_no + LAT)
				else report_mismatch($sformatf("result at edge %0d, expected edge %0d",
					edge_cnt, head.edge_no + LAT));
			end else if (exp_q.size() > 0) begin
				// Oldest result overdue
				assert (edge_cnt < exp_q[0].edge_no + LAT)
				else report_problem($sformatf("no result for the operation accepted at edge %0d",
					exp_q[0].edge_no));
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Run timed out after %0d ns without finishing the tests", WATCHDOG_NS);
		$display("ERRORS FOUND");
		$fatal(1, "Watchdog expired");
	end

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial begin
		int i;
		int gap;
		mad_pkg::mad_operands_t ops;
		nRST = 1'b0;
		ie = 1'b0;
		operands = '0;
		rng_state = SEED;

		// Reset phase
		repeat (RST_CYCLES) begin
			@(negedge MCLK);
			check_idle();
		end
		nRST = 1'b1;
		@(negedge MCLK);
		check_idle();

		// Each row on its own
		for (i = 0; i < NUM_ROWS; i++) begin
			send_op(stim_table[i].ops, stim_table[i].result, int'(stim_table[i].gap));
		end

		// Same rows with ie held high
		for (i = 0; i < NUM_ROWS; i++) begin
			send_op(stim_table[i].ops, stim_table[i].result, 0);
		end

		// Random operands and gaps
		for (i = 0; i < NUM_RANDOM; i++) begin
			rng_state = xorshift32(rng_state);
			ops.a = rng_state[W-1:0];
			rng_state = xorshift32(rng_state);
			ops.b = rng_state[W-1:0];
			rng_state = xorshift32(rng_state);
			ops.c = rng_state[W-1:0];
			rng_state = xorshift32(rng_state);
			gap = int'(rng_state[1:0]);
			send_op(ops, ref_mad(ops), gap);
		end
		@(negedge MCLK);
		ie = 1'b0;

		// Fixed latency of the last operation plus a few quiet cycles for stray strobes
		repeat (LAT + 2) @(negedge MCLK);

		if (exp_q.size() == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			$display("%0d results never arrived", exp_q.size());
			$display("ERRORS FOUND");
			$fatal(1, "Results missing at the end of the run");
		end
	end

endmodule

`default_nettype wire

//--- mad_top.f
+incdir+.
mad_pkg.sv
mad_core.sv
mad_dispatch.sv
mad_collect.sv
mad_top.sv
tb_mad_top.sv

//--- Makefile
# Verilator build and run for the multiply-add engine

SRCS := mad_consts.svh mad_pkg.sv mad_core.sv mad_dispatch.sv \
	mad_collect.sv mad_top.sv tb_mad_top.sv

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_mad_top: $(SRCS) mad_top.f
	verilator --binary --assert --timescale 1ns/1ps \
		--top-module tb_mad_top -f mad_top.f

# Pass only if the log holds the pass message
run: obj_dir/Vtb_mad_top
	./obj_dir/Vtb_mad_top > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "NO ERRORS" sim.log; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
